// File: Bender.yml
package:
  name: sump_trigger

sources:
  - files:
      - hdl/sump_pkg.sv
      - hdl/sump_cmd_rx.sv
      - hdl/sump_cmd_decoder.sv
      - hdl/trigger_stage.sv
      - hdl/trigger_sequencer.sv
      - hdl/sump_trigger_top.sv
  - target: test
    files:
      - verification/tb_sump_trigger.sv

// File: hdl/sump_cmd_decoder.sv
`default_nettype none
`timescale 1ns/1ps

module sump_cmd_decoder #(
  parameter int NUM_STAGES = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_in,
  input  sump_pkg::sump_cmd_t                   cmd_i,
  input  logic                                  cmd_stb_i,
  output sump_pkg::stage_cfg_t [NUM_STAGES-1:0] cfg_o,
  output logic                                  arm_o,
  output logic                                  clear_o
);

  import sump_pkg::*;

  logic [3:0] stage_idx;
  byte_t      kind_op;

  // Stage number sits above the two kind bits
  assign stage_idx = cmd_i.opcode[5:2];
  assign kind_op   = cmd_i.opcode & OP_STAGE_KIND_MASK;

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      cfg_o   <= '0;
      arm_o   <= 1'b0;
      clear_o <= 1'b0;
    end else begin
      arm_o   <= cmd_stb_i && (cmd_i.opcode == OP_ARM);
      clear_o <= cmd_stb_i && (cmd_i.opcode == OP_RESET);

      if (cmd_stb_i) begin
        if (cmd_i.opcode == OP_RESET) begin
          cfg_o <= '0;
        end

        // Stages past NUM_STAGES never match an index here
        for (int k = 0; k < NUM_STAGES; k++) begin
          if (stage_idx == 4'(k)) begin
            case (kind_op)
              OP_TRIG_MASK: begin
                cfg_o[k].mask <= cmd_i.arg;
              end
              OP_TRIG_VALUE: begin
                cfg_o[k].value <= cmd_i.arg;
              end
              OP_TRIG_CONFIG: begin
                cfg_o[k].last <= cmd_i.arg[0];
              end
              default: ;
            endcase
          end
        end
      end
    end
  end

  // A decoded arm or clear is always a single-cycle pulse
  a_pulse_single: assert property (@(posedge clk_i) disable iff (!rst_in)
    (arm_o || clear_o) |=> !(arm_o || clear_o));

endmodule

`default_nettype wire

// File: hdl/sump_cmd_rx.sv
`default_nettype none
`timescale 1ns/1ps

module sump_cmd_rx #(
  parameter int CLK_PER_BIT = 8
) (
  input  logic                clk_i,
  input  logic                rst_in,
  input  logic                rx_i,
  output sump_pkg::sump_cmd_t cmd_o,
  output logic                cmd_stb_o
);

  import sump_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_START,
    ST_SAMPLE,
    ST_STOP,
    ST_WAIT_HIGH
  } rx_state_e;

  localparam int CNT_W = $clog2(CLK_PER_BIT + 1);

  rx_state_e        state;
  logic [CNT_W-1:0] smpl_cnt;
  logic [CNT_W-1:0] smpl_limit;
  logic             take_smpl;
  logic [3:0]       bit_cnt;
  logic [2:0]       byte_cnt;
  byte_t            shift_q;
  byte_t            rx_byte;
  byte_t            opcode_q;
  probe_word_t      arg_q;
  logic             byte_done;
  logic             cmd_done;

  // Half a bit after the start edge, then one full bit per sample
  assign smpl_limit = (state == ST_START) ? CNT_W'(CLK_PER_BIT / 2) : CNT_W'(CLK_PER_BIT);
  assign take_smpl  = (smpl_cnt == smpl_limit - 1'b1);

  // Data arrives LSB first
  assign rx_byte   = {rx_i, shift_q[7:1]};
  assign byte_done = (state == ST_SAMPLE) && take_smpl && (bit_cnt == 4'd7);

  // Opcode MSB clear means a one-byte command
  assign cmd_done  = byte_done && (((byte_cnt == 3'd0) && !rx_byte[7]) || (byte_cnt == 3'd4));

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      state    <= ST_IDLE;
      smpl_cnt <= '0;
      bit_cnt  <= '0;
      byte_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          smpl_cnt <= '0;
          bit_cnt  <= '0;
          if (!rx_i) begin
            state <= ST_START;
          end
        end
        ST_START: begin
          smpl_cnt <= smpl_cnt + 1'b1;
          if (take_smpl) begin
            smpl_cnt <= '0;
            state    <= ST_SAMPLE;
          end
        end
        ST_SAMPLE: begin
          smpl_cnt <= smpl_cnt + 1'b1;
          if (take_smpl) begin
            smpl_cnt <= '0;
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == 4'd7) begin
              bit_cnt <= '0;
              state   <= ST_STOP;
              if (cmd_done) begin
                byte_cnt <= '0;
              end else begin
                byte_cnt <= byte_cnt + 1'b1;
              end
            end
          end
        end
        ST_STOP: begin
          smpl_cnt <= smpl_cnt + 1'b1;
          if (take_smpl) begin
            state <= ST_WAIT_HIGH;
          end
        end
        ST_WAIT_HIGH: begin
          if (rx_i) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      cmd_stb_o <= 1'b0;
    end else begin
      cmd_stb_o <= cmd_done;
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state == ST_SAMPLE) && take_smpl) begin
      shift_q <= rx_byte;
    end
    if (byte_done) begin
      if (byte_cnt == 3'd0) begin
        opcode_q <= rx_byte;
      end else begin
        // Argument bytes come little-endian
        arg_q <= {rx_byte, arg_q[31:8]};
      end
    end
    if (cmd_done) begin
      if (byte_cnt == 3'd0) begin
        cmd_o.opcode <= rx_byte;
        cmd_o.arg    <= '0;
      end else begin
        cmd_o.opcode <= opcode_q;
        cmd_o.arg    <= {rx_byte, arg_q[31:8]};
      end
    end
  end

  a_bit_cnt_range: assert property (@(posedge clk_i) disable iff (!rst_in) bit_cnt < 4'd8);
  a_byte_cnt_range: assert property (@(posedge clk_i) disable iff (!rst_in) byte_cnt <= 3'd5);

endmodule

`default_nettype wire

// File: hdl/sump_pkg.sv
`default_nettype none

package sump_pkg;

  // One UART data byte
  typedef logic [7:0] byte_t;

  // One probe sample, also used as the argument of a long command
  typedef logic [31:0] probe_word_t;

  // Normalized command, arg is zero for short commands
  typedef struct packed {
    byte_t       opcode;
    probe_word_t arg;
  } sump_cmd_t;

  // Per-stage trigger setup
  typedef struct packed {
    probe_word_t mask;
    probe_word_t value;
    logic        last;
  } stage_cfg_t;

  // Short commands
  localparam byte_t OP_RESET = 8'h00;
  localparam byte_t OP_ARM   = 8'h01;

  // Long commands, stage k adds 4*k to the base opcode
  localparam byte_t OP_TRIG_MASK   = 8'hC0;
  localparam byte_t OP_TRIG_VALUE  = 8'hC1;
  localparam byte_t OP_TRIG_CONFIG = 8'hC2;

  // Bits of a stage opcode that select the command kind
  localparam byte_t OP_STAGE_KIND_MASK = 8'hC3;

endpackage

`default_nettype wire

// File: hdl/sump_trigger_top.sv
`default_nettype none
`timescale 1ns/1ps

module sump_trigger_top #(
  parameter int NUM_STAGES  = 4,
  parameter int CLK_PER_BIT = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_in,
  input  logic                  rx_i,
  input  sump_pkg::probe_word_t probe_i,
  output logic                  trig_req_o,
  output sump_pkg::probe_word_t trig_data_o,
  input  logic                  trig_ack_i
);

  import sump_pkg::*;

  sump_cmd_t                    cmd;
  logic                         cmd_stb;
  stage_cfg_t  [NUM_STAGES-1:0] cfg;
  logic                         arm;
  logic                         clear;
  logic                         armed;
  logic        [NUM_STAGES-1:0] stage_en;
  logic        [NUM_STAGES-1:0] fired;
  logic        [NUM_STAGES-1:0] last;
  probe_word_t [NUM_STAGES-1:0] snapshot;

  sump_cmd_rx #(
    .CLK_PER_BIT(CLK_PER_BIT)
  ) i_cmd_rx (
    .clk_i    (clk_i),
    .rst_in   (rst_in),
    .rx_i     (rx_i),
    .cmd_o    (cmd),
    .cmd_stb_o(cmd_stb)
  );

  sump_cmd_decoder #(
    .NUM_STAGES(NUM_STAGES)
  ) i_cmd_decoder (
    .clk_i    (clk_i),
    .rst_in   (rst_in),
    .cmd_i    (cmd),
    .cmd_stb_i(cmd_stb),
    .cfg_o    (cfg),
    .arm_o    (arm),
    .clear_o  (clear)
  );

  // Each stage is enabled by the one before it
  for (genvar k = 0; k < NUM_STAGES; k++) begin : g_stage
    if (k == 0) begin : g_first
      assign stage_en[k] = armed;
    end else begin : g_chain
      assign stage_en[k] = fired[k-1];
    end

    assign last[k] = cfg[k].last;

    trigger_stage i_stage (
      .clk_i     (clk_i),
      .rst_in    (rst_in),
      .armed_i   (armed),
      .enable_i  (stage_en[k]),
      .probe_i   (probe_i),
      .cfg_i     (cfg[k]),
      .fired_o   (fired[k]),
      .snapshot_o(snapshot[k])
    );
  end

  trigger_sequencer #(
    .NUM_STAGES(NUM_STAGES)
  ) i_sequencer (
    .clk_i      (clk_i),
    .rst_in     (rst_in),
    .arm_i      (arm),
    .clear_i    (clear),
    .fired_i    (fired),
    .last_i     (last),
    .snapshot_i (snapshot),
    .armed_o    (armed),
    .trig_req_o (trig_req_o),
    .trig_data_o(trig_data_o),
    .trig_ack_i (trig_ack_i)
  );

endmodule

`default_nettype wire

// File: hdl/trigger_sequencer.sv
`default_nettype none
`timescale 1ns/1ps

module trigger_sequencer #(
  parameter int NUM_STAGES = 4
) (
  input  logic                                   clk_i,
  input  logic                                   rst_in,
  input  logic                                   arm_i,
  input  logic                                   clear_i,
  input  logic [NUM_STAGES-1:0]                  fired_i,
  input  logic [NUM_STAGES-1:0]                  last_i,
  input  sump_pkg::probe_word_t [NUM_STAGES-1:0] snapshot_i,
  output logic                                   armed_o,
  output logic                                   trig_req_o,
  output sump_pkg::probe_word_t                  trig_data_o,
  input  logic                                   trig_ack_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ARMED,
    ST_REQ,
    ST_WAIT_ACK_LOW
  } seq_state_e;

  seq_state_e state;
  logic       hit;
  logic [3:0] sel_idx;

  assign hit = |(fired_i & last_i);

  // Lowest fired stage marked last wins
  always_comb begin
    sel_idx = '0;
    for (int k = NUM_STAGES - 1; k >= 0; k--) begin
      if (fired_i[k] && last_i[k]) begin
        sel_idx = 4'(k);
      end
    end
  end

  // Stages stay armed until the handshake has fully closed
  assign armed_o    = (state != ST_IDLE);
  assign trig_req_o = (state == ST_REQ);

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (arm_i) begin
            state <= ST_ARMED;
          end
        end
        ST_ARMED: begin
          if (clear_i) begin
            state <= ST_IDLE;
          end else if (hit) begin
            state <= ST_REQ;
          end
        end
        ST_REQ: begin
          if (trig_ack_i) begin
            state <= ST_WAIT_ACK_LOW;
          end
        end
        ST_WAIT_ACK_LOW: begin
          if (!trig_ack_i) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state == ST_ARMED) && hit) begin
      trig_data_o <= snapshot_i[sel_idx];
    end
  end

  // Request and data hold until the host acknowledges
  a_req_held: assert property (@(posedge clk_i) disable iff (!rst_in)
    (trig_req_o && !trig_ack_i) |=> (trig_req_o && $stable(trig_data_o)));

endmodule

`default_nettype wire

// File: hdl/trigger_stage.sv
`default_nettype none
`timescale 1ns/1ps

module trigger_stage (
  input  logic                 clk_i,
  input  logic                 rst_in,
  input  logic                 armed_i,
  input  logic                 enable_i,
  input  sump_pkg::probe_word_t probe_i,
  input  sump_pkg::stage_cfg_t  cfg_i,
  output logic                 fired_o,
  output sump_pkg::probe_word_t snapshot_o
);

  logic match;
  logic fire;

  // Only bits set in the mask take part in the compare
  assign match = ((probe_i ^ cfg_i.value) & cfg_i.mask) == '0;
  assign fire  = armed_i && enable_i && match && !fired_o;

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      fired_o <= 1'b0;
    end else if (!armed_i) begin
      fired_o <= 1'b0;
    end else if (fire) begin
      // Sticky until the trigger is disarmed
      fired_o <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!armed_i) begin
      snapshot_o <= '0;
    end else if (fire) begin
      snapshot_o <= probe_i;
    end
  end

endmodule

`default_nettype wire

// File: tb.f
hdl/sump_pkg.sv
hdl/sump_cmd_rx.sv
hdl/sump_cmd_decoder.sv
hdl/trigger_stage.sv
hdl/trigger_sequencer.sv
hdl/sump_trigger_top.sv
verification/tb_sump_trigger.sv

// File: verification/sump_stimulus.txt
# T <test> | C <nbytes> <hex bytes> | P <hex probe> <cycles> <expect req> <hex snapshot>
# R <hex mask> <hex value> <count> drives random probes checked by the masked compare
T 1
C 5 C0 FF 00 00 00
C 5 C1 5A 00 00 00
C 5 C2 01 00 00 00
P 00000000 6 0 0
C 1 01
P 12345600 6 0 0
P ABCDEF5A 3 1 ABCDEF5A
T 2
P 00000000 4 0 0
C 5 C0 F0 0F 00 00
C 5 C1 30 0A 00 00
C 1 01
P FFFFFA3F 4 1 FFFFFA3F
P 00000000 4 0 0
C 1 01
R 00000FF0 00000A30 12
T 3
C 1 00
C 5 C0 FF 00 00 00
C 5 C1 11 00 00 00
C 5 C2 00 00 00 00
C 5 C4 00 FF 00 00
C 5 C5 00 22 00 00
C 5 C6 01 00 00 00
P 00000000 2 0 0
C 1 01
P 00002200 6 0 0
P 00000011 3 0 0
P 00002200 3 1 00002200
T 4
P 00000011 6 0 0
P 00002200 6 0 0
P 00000000 2 0 0
C 1 01
P 00000011 2 0 0
P 12342211 12 1 12342211
P 00002200 6 0 0
P 00000000 2 0 0
C 1 01
P 00000011 2 0 0
P 00002200 3 1 00002200
T 5
C 1 00
P 12340000 2 0 0
C 5 C0 00 00 FF FF
C 1 01
C 5 C1 00 00 EF BE
C 5 C2 01 00 00 00
P 0000BEEF 4 0 0
P BEEF1234 3 1 BEEF1234
T 6
C 1 00
P 00000000 2 0 0
C 1 01
P 00000000 6 0 0
P FFFFFFFF 6 0 0
P 5A5A5A5A 6 0 0

// File: verification/tb_sump_trigger.sv
`default_nettype none
`timescale 1ns/1ps

module tb_sump_trigger;

  import sump_pkg::*;

  localparam int NUM_STAGES  = 4;
  localparam int CLK_PER_BIT = 8;
  localparam int REQ_TIMEOUT = 64;
  localparam int ACK_TIMEOUT = 16;

  logic        clk_i = 1'b0;
  logic        rst_in;
  logic        rx_i;
  probe_word_t probe_i;
  logic        trig_req_o;
  probe_word_t trig_data_o;
  logic        trig_ack_i;

  integer seed = 53;
  int     test_id = 0;
  int     test_checks = 0;
  int     test_errors = 0;
  int     num_tests = 0;
  int     total_checks = 0;
  int     total_errors = 0;
  bit     aborted = 1'b0;

  always #2 clk_i = ~clk_i;

  sump_trigger_top #(
    .NUM_STAGES (NUM_STAGES),
    .CLK_PER_BIT(CLK_PER_BIT)
  ) i_dut (
    .clk_i      (clk_i),
    .rst_in     (rst_in),
    .rx_i       (rx_i),
    .probe_i    (probe_i),
    .trig_req_o (trig_req_o),
    .trig_data_o(trig_data_o),
    .trig_ack_i (trig_ack_i)
  );

  // Step to just after the next rising edge, where inputs change
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    test_errors++;
  endtask

  // One 8N1 frame, LSB first
  task automatic send_byte(input byte_t data);
    rx_i = 1'b0;
    repeat (CLK_PER_BIT) next_cycle();
    for (int i = 0; i < 8; i++) begin
      rx_i = data[i];
      repeat (CLK_PER_BIT) next_cycle();
    end
    rx_i = 1'b1;
    // Stop bit plus a short idle gap
    repeat (CLK_PER_BIT + 2) next_cycle();
  endtask

  task automatic expect_quiet(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      next_cycle();
      test_checks++;
      if (trig_req_o !== 1'b0) begin
        report_error("unexpected trigger request");
      end
    end
  endtask

  // Waits for req, checks the snapshot, holds off ack, then closes the handshake
  task automatic expect_report(input probe_word_t snap, input int ack_delay);
    int          n;
    probe_word_t held;
    n = 0;
    while (trig_req_o !== 1'b1 && n < REQ_TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (trig_req_o !== 1'b1) begin
      $display("Timeout: no trigger request within %0d cycles at %0t ns", REQ_TIMEOUT, $time);
      aborted = 1'b1;
    end else begin
      test_checks++;
      if (trig_data_o !== snap) begin
        report_error($sformatf("trigger data 0x%08h, expected 0x%08h", trig_data_o, snap));
      end
      held = trig_data_o;
      for (int i = 0; i < ack_delay; i++) begin
        next_cycle();
        test_checks++;
        if (trig_req_o !== 1'b1 || trig_data_o !== held) begin
          report_error("request or data changed before acknowledge");
        end
      end
      trig_ack_i = 1'b1;
      n = 0;
      while (trig_req_o !== 1'b0 && n < ACK_TIMEOUT) begin
        next_cycle();
        n++;
      end
      if (trig_req_o !== 1'b0) begin
        $display("Timeout: trigger request still high after acknowledge at %0t ns", $time);
        aborted = 1'b1;
      end
      next_cycle();
      trig_ack_i = 1'b0;
    end
  endtask

  // Expected result follows from the masked compare of each word
  task automatic random_probes(input probe_word_t mask, input probe_word_t value,
                               input int count);
    probe_word_t word;
    logic        hit;
    for (int i = 0; i < count && !aborted; i++) begin
      word = $random(seed);
      // Force the masked bits to the compare value about half of the time
      if ($random(seed) & 1) begin
        word = (word & ~mask) | (value & mask);
      end
      hit = (word & mask) == (value & mask);
      probe_i = word;
      if (hit) begin
        expect_report(word, 2);
        probe_i = value ^ mask;
        send_byte(OP_ARM);
      end else begin
        expect_quiet(4);
      end
    end
  endtask

  task automatic finish_test();
    if (test_id != 0) begin
      $display("Test %0d finished: %0d checks, %0d errors", test_id, test_checks, test_errors);
      num_tests++;
      total_checks += test_checks;
      total_errors += test_errors;
    end
    test_checks = 0;
    test_errors = 0;
  endtask

  initial begin : main_flow
    int                fd;
    int                r;
    int                nbytes;
    int                hold;
    int                expect_req;
    int                count;
    logic [7:0]        kind;
    logic [8*256-1:0]  rest;
    byte_t             data;
    probe_word_t       value;
    probe_word_t       snap;
    probe_word_t       mask;
    probe_word_t       last_hit;
    bit                cfg_cleared;
    bit                done;

    rst_in      = 1'b0;
    rx_i        = 1'b1;
    probe_i     = '0;
    trig_ack_i  = 1'b0;
    last_hit    = '0;
    cfg_cleared = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_in = 1'b1;
    next_cycle();

    fd = $fopen("verification/sump_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file");
      aborted = 1'b1;
    end
    done = (fd == 0);

    while (!done && !aborted) begin
      r = $fscanf(fd, " %c", kind);
      if (r != 1) begin
        done = 1'b1;
      end else if (kind == "#") begin
        r = $fgets(rest, fd);
      end else if (kind == "T") begin
        finish_test();
        r = $fscanf(fd, "%d", test_id);
      end else if (kind == "C") begin
        r = $fscanf(fd, "%d", nbytes);
        for (int i = 0; i < nbytes; i++) begin
          r = $fscanf(fd, "%h", data);
          // A reset clears every stage, a long command writes one again
          if (i == 0 && data == OP_RESET) begin
            cfg_cleared = 1'b1;
          end else if (i == 0 && data[7]) begin
            cfg_cleared = 1'b0;
          end
          send_byte(data);
        end
      end else if (kind == "P") begin
        r = $fscanf(fd, "%h %d %d %h", value, hold, expect_req, snap);
        if (expect_req != 0) begin
          probe_i = value;
          expect_report(snap, hold);
          last_hit = snap;
        end else begin
          // With every stage cleared the last word that fired must stay quiet too
          if (cfg_cleared) begin
            probe_i = last_hit;
            expect_quiet(hold);
          end
          probe_i = value;
          expect_quiet(hold);
        end
      end else if (kind == "R") begin
        r = $fscanf(fd, "%h %h %d", mask, value, count);
        random_probes(mask, value, count);
      end else begin
        $display("Unknown step kind in the stimulus file at %0t ns", $time);
        aborted = 1'b1;
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    finish_test();
    $display("Tests: %0d, checks: %0d, errors: %0d", num_tests, total_checks, total_errors);
    if (aborted || total_errors != 0) begin
      $display("Simulation failed");
    end else begin
      $display("Simulation passed");
    end
    $finish;
  end

endmodule

`default_nettype wire
